/* command.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcu_cmd_params.svh"

module command (
	input wire clk,
	input wire rst_n,
	output logic take,
	input wire arg_valid,
	input wire [31:0] arg_data,
	output mcu_cmd_pkg::unit_req_t sys_req,
	output mcu_cmd_pkg::unit_req_t pwm_req,
	input wire mcu_cmd_pkg::unit_rsp_t sys_rsp,
	input wire mcu_cmd_pkg::unit_rsp_t pwm_rsp,
	output logic sys_cmd_ready,
	output logic pwm_cmd_ready,
	output logic enc_valid,
	output logic [31:0] enc_value,
	output logic enc_raw,
	output logic enc_last,
	input wire enc_busy
);

	localparam int ARG_BITS = $clog2(`MCU_MAX_ARGS);
	localparam int PIDX_BITS = $clog2(`MCU_MAX_PARAMS);

	// command table. ids that are not listed map to no unit.
	function automatic mcu_cmd_pkg::cmd_entry_t lookup(input logic [31:0] id);
		mcu_cmd_pkg::cmd_entry_t e;
		e = '{unit: mcu_cmd_pkg::unit_none, nargs: 3'd0, has_rsp: 1'b0};
		if (id[31:8] == 24'd0) begin
			case (mcu_cmd_pkg::cmd_id_e'(id[7:0]))
				mcu_cmd_pkg::cmd_get_version:
					e = '{unit: mcu_cmd_pkg::unit_system, nargs: 3'd0, has_rsp: 1'b1};
				mcu_cmd_pkg::cmd_get_time:
					e = '{unit: mcu_cmd_pkg::unit_system, nargs: 3'd0, has_rsp: 1'b1};
				mcu_cmd_pkg::cmd_config_pwm:
					e = '{unit: mcu_cmd_pkg::unit_pwm, nargs: 3'd3, has_rsp: 1'b0};
				mcu_cmd_pkg::cmd_schedule_pwm:
					e = '{unit: mcu_cmd_pkg::unit_pwm, nargs: 3'd3, has_rsp: 1'b0};
				default: e.unit = mcu_cmd_pkg::unit_none;
			endcase
		end
		return e;
	endfunction

	mcu_cmd_pkg::cmd_state_e state;
	mcu_cmd_pkg::cmd_entry_t entry;
	mcu_cmd_pkg::cmd_entry_t id_entry;
	mcu_cmd_pkg::cmd_id_e cmd_q;
	mcu_cmd_pkg::unit_rsp_t rsp;
	mcu_cmd_pkg::unit_req_t req;

	logic have_id;
	logic msg_end;
	logic [ARG_BITS-1:0] arg_cnt;
	logic [ARG_BITS-1:0] arg_ptr;
	logic [31:0] args [`MCU_MAX_ARGS];
	logic [31:0] cur_arg;
	logic [31:0] params [`MCU_MAX_PARAMS];
	logic [PIDX_BITS:0] nparams;
	logic [PIDX_BITS:0] send_idx;
	logic [PIDX_BITS:0] prev_idx;
	logic [7:0] rsp_id;
	logic enc_go;

	// only the unit that was dispatched to is listened to.
	assign rsp = (entry.unit == mcu_cmd_pkg::unit_pwm) ? pwm_rsp : sys_rsp;
	assign req = '{cmd: cmd_q, arg: cur_arg};
	assign sys_req = req;
	assign pwm_req = req;
	assign prev_idx = send_idx - 1'b1;
	assign enc_go = (state == mcu_cmd_pkg::st_send) && !enc_valid && !enc_busy;

	// take drops in the same cycle as the value that ends a message, so
	// the decoder does not start on the next message.
	always_comb begin
		id_entry = lookup(arg_data);
		if (!have_id) begin
			msg_end = (id_entry.unit == mcu_cmd_pkg::unit_none) || (id_entry.nargs == 3'd0);
		end else begin
			msg_end = (int'(arg_cnt) + 1 == int'(entry.nargs));
		end
		take = (state == mcu_cmd_pkg::st_args) && !(arg_valid && msg_end);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mcu_cmd_pkg::st_idle;
			entry <= '{unit: mcu_cmd_pkg::unit_none, nargs: 3'd0, has_rsp: 1'b0};
			cmd_q <= mcu_cmd_pkg::cmd_get_version;
			have_id <= 1'b0;
			arg_cnt <= '0;
			arg_ptr <= '0;
			nparams <= '0;
			send_idx <= '0;
			sys_cmd_ready <= 1'b0;
			pwm_cmd_ready <= 1'b0;
			enc_valid <= 1'b0;
		end else begin
			sys_cmd_ready <= 1'b0;
			pwm_cmd_ready <= 1'b0;
			enc_valid <= 1'b0;
			case (state)
				mcu_cmd_pkg::st_idle: begin
					have_id <= 1'b0;
					arg_cnt <= '0;
					state <= mcu_cmd_pkg::st_args;
				end
				mcu_cmd_pkg::st_args: begin
					if (arg_valid && !have_id) begin
						have_id <= 1'b1;
						entry <= id_entry;
						cmd_q <= mcu_cmd_pkg::cmd_id_e'(arg_data[7:0]);
						if (id_entry.unit == mcu_cmd_pkg::unit_none) begin
							state <= mcu_cmd_pkg::st_idle;
						end else if (msg_end) begin
							state <= mcu_cmd_pkg::st_dispatch;
						end
					end else if (arg_valid) begin
						arg_cnt <= arg_cnt + 1'b1;
						if (msg_end) begin
							state <= mcu_cmd_pkg::st_dispatch;
						end
					end
				end
				mcu_cmd_pkg::st_dispatch: begin
					sys_cmd_ready <= (entry.unit == mcu_cmd_pkg::unit_system);
					pwm_cmd_ready <= (entry.unit == mcu_cmd_pkg::unit_pwm);
					arg_ptr <= ARG_BITS'(1);
					nparams <= '0;
					state <= mcu_cmd_pkg::st_wait_done;
				end
				mcu_cmd_pkg::st_wait_done: begin
					if (rsp.arg_advance) begin
						arg_ptr <= arg_ptr + 1'b1;
					end
					if (rsp.param_write) begin
						nparams <= nparams + 1'b1;
					end
					if (rsp.cmd_done) begin
						send_idx <= '0;
						state <= entry.has_rsp ? mcu_cmd_pkg::st_send : mcu_cmd_pkg::st_idle;
					end
				end
				mcu_cmd_pkg::st_send: begin
					// index 0 is the raw response id, then the stored values.
					if (enc_go) begin
						enc_valid <= 1'b1;
						send_idx <= send_idx + 1'b1;
						if (send_idx == nparams) begin
							state <= mcu_cmd_pkg::st_idle;
						end
					end
				end
				default: state <= mcu_cmd_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mcu_cmd_pkg::st_args && arg_valid && have_id) begin
			args[arg_cnt] <= arg_data;
		end
		if (state == mcu_cmd_pkg::st_dispatch) begin
			cur_arg <= args[0];
		end else if (state == mcu_cmd_pkg::st_wait_done && rsp.arg_advance) begin
			cur_arg <= args[arg_ptr];
		end
		if (state == mcu_cmd_pkg::st_wait_done && rsp.param_write) begin
			params[nparams[PIDX_BITS-1:0]] <= rsp.param_data;
		end
		if (state == mcu_cmd_pkg::st_wait_done && rsp.cmd_done) begin
			rsp_id <= rsp.param_data[7:0];
		end
		if (enc_go) begin
			enc_value <= (send_idx == '0) ? {24'd0, rsp_id} :
				params[prev_idx[PIDX_BITS-1:0]];
			enc_raw <= (send_idx == '0);
			enc_last <= (send_idx == nparams);
		end
	end

endmodule

`default_nettype wire

/* mcu_cmd.f */
+incdir+.
mcu_cmd_pkg.sv
vlq_decoder.sv
command.sv
vlq_encoder.sv
system_unit.sv
pwm_unit.sv
mcu_cmd_top.sv
tb_mcu_cmd.sv

/* mcu_cmd_params.svh */
`ifndef MCU_CMD_PARAMS_SVH
`define MCU_CMD_PARAMS_SVH

// version word returned by get_version.
`define MCU_VERSION 32'h0001_0203

// number of PWM outputs driven by the PWM unit.
`define MCU_NPWM 4

// size of the argument store in the command block.
`define MCU_MAX_ARGS 8

// number of response values the command block can hold.
`define MCU_MAX_PARAMS 8

`endif

/* mcu_cmd_pkg.sv */
`default_nettype none

package mcu_cmd_pkg;

	// command ids as they appear on the wire from the host.
	typedef enum logic [7:0] {
		cmd_get_version = 8'd0,
		cmd_get_time = 8'd2,
		cmd_config_pwm = 8'd3,
		cmd_schedule_pwm = 8'd4
	} cmd_id_e;

	typedef enum logic [3:0] {
		unit_pwm = 4'd0,
		unit_system = 4'd1,
		unit_none = 4'd15
	} unit_e;

	// first byte of every response, sent raw.
	typedef enum logic [7:0] {
		rsp_version = 8'd0,
		rsp_time = 8'd1
	} rsp_id_e;

	typedef struct packed {
		unit_e unit;
		logic [2:0] nargs;
		logic has_rsp;
	} cmd_entry_t;

	typedef struct packed {
		cmd_id_e cmd;
		logic [31:0] arg;
	} unit_req_t;

	typedef struct packed {
		logic arg_advance;
		logic param_write;
		logic cmd_done;
		logic [31:0] param_data;
	} unit_rsp_t;

	typedef enum logic [2:0] {
		st_idle,
		st_args,
		st_dispatch,
		st_wait_done,
		st_send
	} cmd_state_e;

endpackage

`default_nettype wire

/* mcu_cmd_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcu_cmd_params.svh"

module mcu_cmd_top (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output logic msg_rd_en,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input wire send_ring_full,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input wire send_fifo_full,
	input wire [63:0] systime,
	output logic [`MCU_NPWM-1:0] pwm
);

	logic take;
	logic arg_valid;
	logic [31:0] arg_data;
	mcu_cmd_pkg::unit_req_t sys_req;
	mcu_cmd_pkg::unit_req_t pwm_req;
	mcu_cmd_pkg::unit_rsp_t sys_rsp;
	mcu_cmd_pkg::unit_rsp_t pwm_rsp;
	logic sys_cmd_ready;
	logic pwm_cmd_ready;
	logic enc_valid;
	logic [31:0] enc_value;
	logic enc_raw;
	logic enc_last;
	logic enc_busy;

	vlq_decoder u_dec (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.take(take),
		.msg_rd_en(msg_rd_en),
		.arg_valid(arg_valid),
		.arg_data(arg_data)
	);

	command u_cmd (
		.clk(clk),
		.rst_n(rst_n),
		.take(take),
		.arg_valid(arg_valid),
		.arg_data(arg_data),
		.sys_req(sys_req),
		.pwm_req(pwm_req),
		.sys_rsp(sys_rsp),
		.pwm_rsp(pwm_rsp),
		.sys_cmd_ready(sys_cmd_ready),
		.pwm_cmd_ready(pwm_cmd_ready),
		.enc_valid(enc_valid),
		.enc_value(enc_value),
		.enc_raw(enc_raw),
		.enc_last(enc_last),
		.enc_busy(enc_busy)
	);

	vlq_encoder u_enc (
		.clk(clk),
		.rst_n(rst_n),
		.enc_valid(enc_valid),
		.enc_value(enc_value),
		.enc_raw(enc_raw),
		.enc_last(enc_last),
		.enc_busy(enc_busy),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full)
	);

	system_unit u_sys (
		.clk(clk),
		.rst_n(rst_n),
		.systime(systime),
		.cmd_ready(sys_cmd_ready),
		.req(sys_req),
		.rsp(sys_rsp)
	);

	pwm_unit u_pwm (
		.clk(clk),
		.rst_n(rst_n),
		.systime(systime),
		.cmd_ready(pwm_cmd_ready),
		.req(pwm_req),
		.rsp(pwm_rsp),
		.pwm(pwm)
	);

endmodule

`default_nettype wire

/* pwm_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcu_cmd_params.svh"

module pwm_unit (
	input wire clk,
	input wire rst_n,
	input wire [63:0] systime,
	input wire cmd_ready,
	input wire mcu_cmd_pkg::unit_req_t req,
	output mcu_cmd_pkg::unit_rsp_t rsp,
	output logic [`MCU_NPWM-1:0] pwm
);

	localparam int CH_BITS = (`MCU_NPWM > 1) ? $clog2(`MCU_NPWM) : 1;

	typedef enum logic [1:0] {
		pwm_idle,
		pwm_arg1,
		pwm_arg2,
		pwm_apply
	} pwm_state_e;

	pwm_state_e state;
	mcu_cmd_pkg::cmd_id_e cmd_q;
	logic [CH_BITS-1:0] chan_q;
	logic [31:0] a1;

	// both commands take three arguments; the third is applied as it arrives.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= pwm_idle;
		end else if (cmd_ready) begin
			state <= pwm_arg1;
		end else begin
			case (state)
				pwm_arg1: state <= pwm_arg2;
				pwm_arg2: state <= pwm_apply;
				default: state <= pwm_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_ready) begin
			cmd_q <= req.cmd;
			chan_q <= req.arg[CH_BITS-1:0];
		end
		if (state == pwm_arg2) begin
			a1 <= req.arg;
		end
	end

	always_comb begin
		rsp = '0;
		rsp.arg_advance = (state == pwm_arg1) || (state == pwm_arg2);
		rsp.cmd_done = (state == pwm_apply);
	end

	for (genvar i = 0; i < `MCU_NPWM; i++) begin : g_ch
		logic [31:0] period;
		logic [31:0] on_ticks;
		logic [31:0] cnt;
		logic [31:0] sched_clock;
		logic [31:0] sched_on;
		logic pending;
		logic pwm_q;
		logic hit;

		assign hit = (state == pwm_apply) && (int'(chan_q) == i);
		assign pwm[i] = pwm_q;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				period <= 32'd0;
				on_ticks <= 32'd0;
				cnt <= 32'd0;
				sched_clock <= 32'd0;
				sched_on <= 32'd0;
				pending <= 1'b0;
				pwm_q <= 1'b0;
			end else begin
				cnt <= (cnt + 32'd1 >= period) ? 32'd0 : cnt + 32'd1;
				pwm_q <= (cnt < on_ticks);
				if (hit && cmd_q == mcu_cmd_pkg::cmd_config_pwm) begin
					period <= a1;
					on_ticks <= req.arg;
					cnt <= 32'd0;
					pending <= 1'b0;
				end else if (hit) begin
					sched_clock <= a1;
					sched_on <= req.arg;
					pending <= 1'b1;
				end else if (pending && systime[31:0] == sched_clock) begin
					on_ticks <= sched_on;
					pending <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it. The exit status is zero only
# when the simulation prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f mcu_cmd.f \
	--top-module tb_mcu_cmd -o sim_tb_mcu_cmd &&
./obj_dir/sim_tb_mcu_cmd | grep -q "^=== PASS ===$" &&
echo "simulation run: passed" ||
{ echo "simulation run: failed"; exit 1; }

/* system_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcu_cmd_params.svh"

module system_unit (
	input wire clk,
	input wire rst_n,
	input wire [63:0] systime,
	input wire cmd_ready,
	input wire mcu_cmd_pkg::unit_req_t req,
	output mcu_cmd_pkg::unit_rsp_t rsp
);

	typedef enum logic [1:0] {
		sys_idle,
		sys_word0,
		sys_word1,
		sys_done
	} sys_state_e;

	sys_state_e state;
	mcu_cmd_pkg::cmd_id_e cmd_q;
	logic [63:0] time_q;
	logic is_time;

	assign is_time = (cmd_q == mcu_cmd_pkg::cmd_get_time);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= sys_idle;
		end else if (cmd_ready) begin
			state <= sys_word0;
		end else begin
			case (state)
				sys_word0: state <= is_time ? sys_word1 : sys_done;
				sys_word1: state <= sys_done;
				default: state <= sys_idle;
			endcase
		end
	end

	// the time is sampled when the command arrives.
	always_ff @(posedge clk) begin
		if (cmd_ready) begin
			cmd_q <= req.cmd;
			time_q <= systime;
		end
	end

	always_comb begin
		rsp = '0;
		case (state)
			sys_word0: begin
				rsp.param_write = 1'b1;
				rsp.param_data = is_time ? time_q[31:0] : `MCU_VERSION;
			end
			sys_word1: begin
				rsp.param_write = 1'b1;
				rsp.param_data = time_q[63:32];
			end
			sys_done: begin
				rsp.cmd_done = 1'b1;
				rsp.param_data = {24'd0, is_time ? mcu_cmd_pkg::rsp_time :
					mcu_cmd_pkg::rsp_version};
			end
			default: rsp = '0;
		endcase
	end

endmodule

`default_nettype wire

/* tb_mcu_cmd.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mcu_cmd_params.svh"

module tb_mcu_cmd;

	localparam int K_VERSION = 0;
	localparam int K_TIME = 1;
	localparam int K_SILENT = 2;
	localparam int K_DUTY = 3;
	localparam int K_SCHED = 4;

	typedef struct packed {
		logic [3:0] kind;
		logic [7:0] id;
		logic [1:0] nargs;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [7:0] full_cycles;
	} test_t;

	logic clk;
	logic rst_n;
	logic [7:0] msg_data;
	logic msg_ready;
	wire msg_rd_en;
	wire [7:0] send_ring_data;
	wire send_ring_wr_en;
	logic send_ring_full;
	wire [7:0] send_fifo_data;
	wire send_fifo_wr_en;
	logic send_fifo_full;
	logic [63:0] systime;
	wire [`MCU_NPWM-1:0] pwm;

	logic [7:0] rx_q[$];
	logic [7:0] ring_q[$];
	logic [7:0] fifo_q[$];
	logic [7:0] exp_q[$];
	test_t tests[$];
	logic pop_flag;
	logic seen_pop;
	logic [63:0] pop_time;
	logic [63:0] fifo_time;
	logic [15:0] lfsr;
	int errors;
	int failed_tests;
	int cycles;
	int limit;
	int cur_p;
	int cur_d;

	mcu_cmd_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full),
		.systime(systime),
		.pwm(pwm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// host-side FIFO and ring models. A byte leaves the receive queue on the
	// falling edge after its pop cycle, since the decoder reads it at the rising edge.
	always @(negedge clk) begin
		if (pop_flag && rx_q.size() != 0) begin
			rx_q.delete(0);
		end
		if (pop_flag && msg_rd_en) begin
			$display("msg_rd_en was high on two cycles in a row");
			errors++;
		end
		pop_flag = msg_rd_en;
		if (msg_rd_en && !seen_pop) begin
			seen_pop = 1'b1;
			pop_time = systime;
		end
		if (send_ring_wr_en && send_ring_full) begin
			$display("the send ring was written while send_ring_full was high");
			errors++;
		end
		if (send_ring_wr_en) begin
			ring_q.push_back(send_ring_data);
		end
		if (send_fifo_wr_en) begin
			fifo_q.push_back(send_fifo_data);
			fifo_time = systime;
		end
		systime = systime + 64'd1;
		msg_ready = (rx_q.size() != 0);
		msg_data = msg_ready ? rx_q[0] : 8'h00;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// 16-bit Fibonacci LFSR, taps 16 14 13 11.
	function automatic logic lfsr_step();
		logic b;
		b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], b};
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = 32'd0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_step()};
		end
		return r;
	endfunction

	// shortest signed VLQ. n groups hold -(2^(7n-2)) up to 3*2^(7n-2)-1.
	task automatic append_vlq(input logic [31:0] v, input logic to_rx);
		longint sv;
		int n;
		logic [7:0] b;
		sv = longint'(signed'(v));
		n = 1;
		while (n < 5 && !(sv >= -(64'sd1 <<< (7 * n - 2)) && sv < (64'sd3 <<< (7 * n - 2)))) begin
			n++;
		end
		for (int i = n - 1; i >= 0; i--) begin
			b = {(i > 0), 7'(sv >>> (7 * i))};
			if (to_rx) begin
				rx_q.push_back(b);
			end else begin
				exp_q.push_back(b);
			end
		end
	endtask

	task automatic decode_value(inout int pos, output logic [31:0] v);
		logic [7:0] b;
		logic first;
		first = 1'b1;
		v = 32'd0;
		forever begin
			if (pos >= ring_q.size()) begin
				$display("response ended in the middle of a value");
				errors++;
				break;
			end
			b = ring_q[pos];
			pos++;
			if (first) begin
				v = (b[6] & b[5]) ? 32'hffff_ffff : 32'd0;
			end
			first = 1'b0;
			v = {v[24:0], b[6:0]};
			if (!b[7]) begin
				break;
			end
		end
	endtask

	task automatic add_test(input int kind, input logic [7:0] id, input int nargs,
		input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] a2, input int full);
		test_t t;
		t = '{kind: 4'(kind), id: id, nargs: 2'(nargs), a0: a0, a1: a1, a2: a2,
			full_cycles: 8'(full)};
		tests.push_back(t);
		limit = limit + 200 + 20 * nargs + full;
		if (kind == K_DUTY || kind == K_SCHED) begin
			limit = limit + int'(a1) + 600;
		end
	endtask

	task automatic wait_len();
		while (fifo_q.size() == 0) @(posedge clk);
		@(posedge clk);
		if (fifo_q.size() != 1 || fifo_q[0] != 8'(ring_q.size())) begin
			$display("Error: send_fifo_data got %h exp %h", fifo_q[0], 8'(ring_q.size()));
			errors++;
		end
	endtask

	task automatic wait_silent();
		while (rx_q.size() != 0) @(posedge clk);
		// pwm commands finish a fixed few cycles after the last byte.
		repeat (12) @(posedge clk);
		if (ring_q.size() != 0 || fifo_q.size() != 0) begin
			$display("a command without a response wrote to the send ring or send FIFO");
			errors++;
		end
	endtask

	task automatic check_duty(input int chan, input int nper, input int on_ticks);
		int cnt;
		cnt = 0;
		repeat (nper * cur_p) begin
			@(negedge clk);
			cnt += int'(pwm[chan]);
		end
		if (cnt != nper * on_ticks) begin
			$display("Error: pwm[%0d] high cycles got %h exp %h", chan, cnt, nper * on_ticks);
			errors++;
		end
	endtask

	task automatic run_test(input int idx);
		test_t t;
		int errs0;
		int pos;
		logic [31:0] v_lo;
		logic [31:0] v_hi;
		logic [63:0] tm;
		logic [31:0] clk_at;
		t = tests[idx];
		errs0 = errors;
		@(posedge clk);
		ring_q.delete();
		fifo_q.delete();
		exp_q.delete();
		seen_pop = 1'b0;
		clk_at = systime[31:0] + t.a1;
		append_vlq({24'd0, t.id}, 1'b1);
		if (t.nargs >= 1) append_vlq(t.a0, 1'b1);
		if (t.nargs >= 2) append_vlq((t.kind == K_SCHED) ? clk_at : t.a1, 1'b1);
		if (t.nargs >= 3) append_vlq(t.a2, 1'b1);
		if (t.full_cycles != 0) begin
			@(negedge clk);
			send_ring_full = 1'b1;
			repeat (int'(t.full_cycles)) @(negedge clk);
			send_ring_full = 1'b0;
		end
		case (int'(t.kind))
			K_VERSION: begin
				wait_len();
				exp_q.push_back(8'h00);
				append_vlq(`MCU_VERSION, 1'b0);
				if (ring_q.size() != exp_q.size()) begin
					$display("version response has %0d bytes, expected %0d",
						ring_q.size(), exp_q.size());
					errors++;
				end else begin
					for (int i = 0; i < exp_q.size(); i++) begin
						if (ring_q[i] != exp_q[i]) begin
							$display("Error: send_ring_data[%0d] got %h exp %h", i, ring_q[i],
								exp_q[i]);
							errors++;
						end
					end
				end
			end
			K_TIME: begin
				wait_len();
				pos = 1;
				if (ring_q[0] != 8'h01) begin
					$display("Error: send_ring_data[0] got %h exp %h", ring_q[0], 8'h01);
					errors++;
				end
				decode_value(pos, v_lo);
				decode_value(pos, v_hi);
				tm = {v_hi, v_lo};
				if (pos != ring_q.size()) begin
					$display("time response has extra bytes after two values");
					errors++;
				end
				if (tm < pop_time || tm > fifo_time) begin
					$display("Error: send_ring_data time got %h exp between %h and %h",
						tm, pop_time, fifo_time);
					errors++;
				end
			end
			K_DUTY: begin
				wait_silent();
				cur_p = int'(t.a1);
				cur_d = int'(t.a2);
				check_duty(int'(t.a0), 3, cur_d);
			end
			K_SCHED: begin
				wait_silent();
				if (systime[31:0] + 32'(2 * cur_p + 2) >= clk_at) begin
					$display("scheduled time passed before the old duty was checked");
					errors++;
				end else begin
					check_duty(int'(t.a0), 2, cur_d);
				end
				while (systime[31:0] <= clk_at + 32'd2) @(posedge clk);
				cur_d = int'(t.a2);
				check_duty(int'(t.a0), 2, cur_d);
			end
			default: wait_silent();
		endcase
		if (errors != errs0) failed_tests++;
		$display("test %0d kind %0d id %0d: %s", idx, t.kind, t.id,
			(errors == errs0) ? "ok" : "FAILED");
	endtask

	initial begin
		int p;
		int d;
		int bounds[$];
		rst_n = 1'b0;
		msg_data = 8'h00;
		msg_ready = 1'b0;
		send_ring_full = 1'b0;
		send_fifo_full = 1'b0;
		systime = 64'd0;
		pop_flag = 1'b0;
		seen_pop = 1'b0;
		pop_time = 64'd0;
		fifo_time = 64'd0;
		lfsr = 16'd48634;
		errors = 0;
		failed_tests = 0;
		cycles = 0;
		limit = 100;
		cur_p = 1;
		cur_d = 0;

		add_test(K_VERSION, 8'd0, 0, 0, 0, 0, 0);
		add_test(K_TIME, 8'd2, 0, 0, 0, 0, 0);
		add_test(K_SILENT, 8'd5, 0, 0, 0, 0, 0);
		p = 4 + int'(rand_bits(5));
		d = int'(rand_bits(6) % 32'(p + 1));
		add_test(K_DUTY, 8'd3, 3, 32'd1, 32'(p), 32'(d), 0);
		// the scheduled on-ticks always differ from the configured ones.
		d = (d + 1 + int'(rand_bits(6) % 32'(p))) % (p + 1);
		add_test(K_SCHED, 8'd4, 3, 32'd1, 32'd200, 32'(d), 0);
		p = 4 + int'(rand_bits(5));
		add_test(K_DUTY, 8'd3, 3, 32'd0, 32'(p), rand_bits(6) % 32'(p + 1), 0);
		// length boundaries of the VLQ, each just inside and just outside.
		bounds = '{'h5f, 'h60, -'h20, -'h21, -'h60, -'h61, 'h2fff, 'h3000, -'h1000, -'h1001,
			-'h3000, 'h17ffff, 'h180000, -'h80000, -'h80001, -'h180000, 'hbffffff, 'hc000000,
			-'h4000000, -'h4000001, -'hc000000};
		for (int i = 0; i < 4; i++) begin
			bounds.push_back(int'(rand_bits(32)));
		end
		foreach (bounds[i]) begin
			add_test(K_SILENT, 8'd4, 3, 32'd3, 32'h7fff_0000, 32'(bounds[i]), 0);
		end
		add_test(K_VERSION, 8'd0, 0, 0, 0, 0, 0);
		add_test(K_VERSION, 8'd0, 0, 0, 0, 0, 30);
		add_test(K_TIME, 8'd2, 0, 0, 0, 0, 0);

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		foreach (tests[i]) begin
			run_test(i);
		end
		$display("tests %0d, failed %0d, errors %0d", tests.size(), failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlq_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module vlq_decoder (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	input wire take,
	output logic msg_rd_en,
	output logic arg_valid,
	output logic [31:0] arg_data
);

	logic first;
	logic [31:0] acc;
	logic neg;

	// a value opening with bits 6 and 5 set is negative.
	assign neg = msg_data[6] & msg_data[5];
	assign arg_data = acc;

	// the pop strobe alternates with idle cycles, so the FIFO head has
	// a full cycle to settle before it is looked at again.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			msg_rd_en <= 1'b0;
		end else if (msg_rd_en) begin
			msg_rd_en <= 1'b0;
		end else begin
			msg_rd_en <= take & msg_ready;
		end
	end

	// the byte is still at the FIFO head during its pop cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first <= 1'b1;
			arg_valid <= 1'b0;
		end else begin
			arg_valid <= 1'b0;
			if (msg_rd_en) begin
				first <= ~msg_data[7];
				arg_valid <= ~msg_data[7];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (msg_rd_en) begin
			if (first) begin
				acc <= {{25{neg}}, msg_data[6:0]};
			end else begin
				acc <= {acc[24:0], msg_data[6:0]};
			end
		end
	end

endmodule

`default_nettype wire

/* vlq_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module vlq_encoder (
	input wire clk,
	input wire rst_n,
	input wire enc_valid,
	input wire [31:0] enc_value,
	input wire enc_raw,
	input wire enc_last,
	output logic enc_busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input wire send_ring_full,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input wire send_fifo_full
);

	typedef enum logic [1:0] {
		enc_idle,
		enc_skip,
		enc_emit,
		enc_len
	} enc_state_e;

	enc_state_e state;
	logic [34:0] sh;
	logic [2:0] cnt;
	logic raw_q;
	logic last_q;
	logic [7:0] len;
	logic redundant;

	// the top group is only sign when the next group already carries it.
	assign redundant = (sh[34:28] == 7'h7f && sh[27:26] == 2'b11) ||
		(sh[34:28] == 7'h00 && sh[27:26] != 2'b11);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= enc_idle;
			enc_busy <= 1'b0;
			cnt <= 3'd0;
			raw_q <= 1'b0;
			last_q <= 1'b0;
			len <= 8'd0;
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
		end else begin
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			case (state)
				enc_idle: begin
					if (enc_valid) begin
						enc_busy <= 1'b1;
						raw_q <= enc_raw;
						last_q <= enc_last;
						cnt <= enc_raw ? 3'd0 : 3'd4;
						state <= enc_raw ? enc_emit : enc_skip;
					end
				end
				enc_skip: begin
					if (cnt != 3'd0 && redundant) begin
						cnt <= cnt - 3'd1;
					end else begin
						state <= enc_emit;
					end
				end
				enc_emit: begin
					if (!send_ring_full) begin
						send_ring_wr_en <= 1'b1;
						len <= len + 8'd1;
						cnt <= cnt - 3'd1;
						if (cnt == 3'd0) begin
							state <= last_q ? enc_len : enc_idle;
							enc_busy <= last_q;
						end
					end
				end
				enc_len: begin
					if (!send_fifo_full) begin
						send_fifo_wr_en <= 1'b1;
						len <= 8'd0;
						enc_busy <= 1'b0;
						state <= enc_idle;
					end
				end
				default: state <= enc_idle;
			endcase
		end
	end

	// values are widened to 35 bits, five groups of seven.
	always_ff @(posedge clk) begin
		if (state == enc_idle && enc_valid) begin
			if (enc_raw) begin
				sh <= {enc_value[7:0], 27'd0};
			end else begin
				sh <= {{3{enc_value[31]}}, enc_value};
			end
		end else if (state == enc_skip && cnt != 3'd0 && redundant) begin
			sh <= {sh[27:0], 7'd0};
		end else if (state == enc_emit && !send_ring_full) begin
			sh <= {sh[27:0], 7'd0};
			if (raw_q) begin
				send_ring_data <= sh[34:27];
			end else begin
				send_ring_data <= {cnt != 3'd0, sh[34:28]};
			end
		end
		if (state == enc_len && !send_fifo_full) begin
			send_fifo_data <= len;
		end
	end

endmodule

`default_nettype wire
